// File: Bender.yml
package:
  name: mpuIssue

sources:
  - files:
      - mpuPkg.sv
      - ringBuffCtrl.sv
      - hazardCheck.sv
      - completionMap.sv
      - mpuIssueStage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbMpuIssueStage.sv

// File: completionMap.sv
`timescale 1ns/100ps

module completionMap #(
	parameter int numEntry = 8
) (
	input logic clock,
	input logic reset,
	input logic issueValid,
	input mpuPkg::issueInfoT issue,
	input logic doneValid,
	input mpuPkg::threadIdT doneId,
	output logic commitValid,
	output logic [$clog2(numEntry)-1:0] commitNo
);

	import mpuPkg::*;

	localparam int IssueNoWidth = $clog2(numEntry);
	localparam int NumThread = 2 ** ThreadIdWidth;

	// One slot per thread ID
	logic [NumThread-1:0] inFlight;
	logic [IssueNoWidth-1:0] slotNo [NumThread];

	// Done clears first, so a reused ID issued in the same cycle stays in flight
	always_ff @(posedge clock) begin
		if (reset) begin
			inFlight <= '0;
		end else begin
			if (doneValid) begin
				inFlight[doneId] <= 1'b0;
			end
			if (issueValid) begin
				inFlight[issue.threadId] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (issueValid) begin
			slotNo[issue.threadId] <= issue.issueNo[IssueNoWidth-1:0];
		end
	end

	// Registered lookup
	always_ff @(posedge clock) begin
		if (reset) begin
			commitValid <= 1'b0;
		end else begin
			commitValid <= doneValid;
		end
	end

	always_ff @(posedge clock) begin
		if (doneValid) begin
			commitNo <= slotNo[doneId];
		end
	end

	doneForInFlight: assert property (
		@(posedge clock) disable iff (reset)
		doneValid |-> inFlight[doneId]
	) else $error("completionMap: done for thread %0d not in flight", doneId);

	issueNotInFlight: assert property (
		@(posedge clock) disable iff (reset)
		issueValid |-> !inFlight[issue.threadId]
			|| (doneValid && doneId == issue.threadId)
	) else $error("completionMap: thread %0d issued twice", issue.threadId);

endmodule

// File: hazardCheck.sv
`timescale 1ns/100ps

module hazardCheck #(
	parameter int numEntry = 8
) (
	input logic clock,
	input logic reset,
	input logic reqValid,
	input mpuPkg::threadReqT req,
	input logic commitValid,
	input logic [$clog2(numEntry)-1:0] commitNo,
	output logic full,
	output logic issueValid,
	output mpuPkg::issueInfoT issue
);

	import mpuPkg::*;

	localparam int IssueNoWidth = $clog2(numEntry);

	hazardEntryT hazardTable [numEntry];

	// Ring pointers
	logic writeEn;
	logic retireEn;
	logic [IssueNoWidth-1:0] writeAddr;
	logic [IssueNoWidth-1:0] retireAddr;
	logic empty;
	logic [IssueNoWidth:0] count;

	// Issue side
	logic [IssueNoWidth-1:0] issuePtr;
	hazardEntryT head;
	hazardEntryT tail;
	logic srcPending;
	logic issuable;
	logic [numEntry-1:0] validVec;

	assign head = hazardTable[issuePtr];
	assign tail = hazardTable[retireAddr];

	assign writeEn = reqValid && !full;
	// Tail goes once it has issued and its result is committed
	assign retireEn = !empty && tail.valid && tail.issued && tail.committed;

	// Rows ahead of the head have all issued, so only those can be sources
	always_comb begin
		srcPending = 1'b0;
		for (int i = 0; i < numEntry; i++) begin
			if (hazardTable[i].valid && hazardTable[i].issued
					&& !hazardTable[i].committed
					&& hazardTable[i].threadId == head.srcId) begin
				srcPending = 1'b1;
			end
		end
	end

	assign issuable = head.valid && !head.issued && (!head.hasSrc || !srcPending);

	always_comb begin
		for (int i = 0; i < numEntry; i++) begin
			validVec[i] = hazardTable[i].valid;
		end
	end

	// Table rows
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < numEntry; i++) begin
				hazardTable[i].valid <= 1'b0;
				hazardTable[i].issued <= 1'b0;
				hazardTable[i].committed <= 1'b0;
			end
		end else begin
			if (writeEn) begin
				hazardTable[writeAddr].valid <= 1'b1;
				hazardTable[writeAddr].issued <= 1'b0;
				hazardTable[writeAddr].committed <= 1'b0;
				hazardTable[writeAddr].hasSrc <= req.hasSrc;
				hazardTable[writeAddr].threadId <= req.threadId;
				hazardTable[writeAddr].srcId <= req.srcId;
			end
			if (issuable) begin
				hazardTable[issuePtr].issued <= 1'b1;
			end
			if (commitValid) begin
				hazardTable[commitNo].committed <= 1'b1;
			end
			if (retireEn) begin
				hazardTable[retireAddr].valid <= 1'b0;
				hazardTable[retireAddr].issued <= 1'b0;
				hazardTable[retireAddr].committed <= 1'b0;
			end
		end
	end

	// Issue pointer and registered strobe
	always_ff @(posedge clock) begin
		if (reset) begin
			issuePtr <= '0;
			issueValid <= 1'b0;
		end else begin
			issueValid <= issuable;
			if (issuable) begin
				issuePtr <= issuePtr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (issuable) begin
			issue.threadId <= head.threadId;
			issue.issueNo <= MaxIssueNoWidth'(issuePtr);
		end
	end

	ringBuffCtrl #(
		.numEntry(numEntry)
	) ringBuffCtrl_i (
		.clock(clock),
		.reset(reset),
		.writeEn(writeEn),
		.retireEn(retireEn),
		.writeAddr(writeAddr),
		.retireAddr(retireAddr),
		.full(full),
		.empty(empty),
		.count(count)
	);

	// Completion map only reports threads that are out and not yet committed
	commitToIssuedRow: assert property (
		@(posedge clock) disable iff (reset)
		commitValid |-> hazardTable[commitNo].valid && hazardTable[commitNo].issued
	) else $error("hazardCheck: commit to a row that is not in flight");

	// Ring count tracks the valid rows
	countMatchesTable: assert property (
		@(posedge clock) disable iff (reset)
		$countones(validVec) == count
	) else $error("hazardCheck: ring count disagrees with table");

endmodule

// File: mpuIssue.f
+incdir+.
mpuPkg.sv
ringBuffCtrl.sv
hazardCheck.sv
completionMap.sv
mpuIssueStage.sv
tbMpuIssueStage.sv

// File: mpuIssueStage.sv
`timescale 1ns/100ps

module mpuIssueStage #(
	parameter int numEntry = 8
) (
	input logic clock,
	input logic reset,
	input logic reqValid,
	input mpuPkg::threadReqT req,
	input logic doneValid,
	input mpuPkg::threadIdT doneId,
	output logic full,
	output logic issueValid,
	output mpuPkg::issueInfoT issue
);

	// Commit path back into the hazard table
	logic commitValid;
	logic [$clog2(numEntry)-1:0] commitNo;

	hazardCheck #(
		.numEntry(numEntry)
	) hazardCheck_i (
		.clock(clock),
		.reset(reset),
		.reqValid(reqValid),
		.req(req),
		.commitValid(commitValid),
		.commitNo(commitNo),
		.full(full),
		.issueValid(issueValid),
		.issue(issue)
	);

	// Issues are seen here as well as at the outputs
	completionMap #(
		.numEntry(numEntry)
	) completionMap_i (
		.clock(clock),
		.reset(reset),
		.issueValid(issueValid),
		.issue(issue),
		.doneValid(doneValid),
		.doneId(doneId),
		.commitValid(commitValid),
		.commitNo(commitNo)
	);

endmodule

// File: mpuPkg.sv
package mpuPkg;

	// Scalar thread ID
	localparam int ThreadIdWidth = 5;

	// Room for the issue number in issueInfoT
	// Each module uses the low $clog2(numEntry) bits
	localparam int MaxIssueNoWidth = 8;

	typedef logic [ThreadIdWidth-1:0] threadIdT;

	// Request from the front end
	typedef struct packed {
		threadIdT threadId;
		// Set when the thread needs another thread's result
		logic hasSrc;
		threadIdT srcId;
	} threadReqT;

	// One row of the hazard table
	typedef struct packed {
		logic valid;
		logic issued;
		logic committed;
		logic hasSrc;
		threadIdT threadId;
		threadIdT srcId;
	} hazardEntryT;

	// Issued thread with its table slot
	typedef struct packed {
		threadIdT threadId;
		logic [MaxIssueNoWidth-1:0] issueNo;
	} issueInfoT;

endpackage

// File: ringBuffCtrl.sv
`timescale 1ns/100ps

module ringBuffCtrl #(
	parameter int numEntry = 8
) (
	input logic clock,
	input logic reset,
	input logic writeEn,
	input logic retireEn,
	output logic [$clog2(numEntry)-1:0] writeAddr,
	output logic [$clog2(numEntry)-1:0] retireAddr,
	output logic full,
	output logic empty,
	output logic [$clog2(numEntry):0] count
);

	localparam int AddrWidth = $clog2(numEntry);
	localparam logic [AddrWidth:0] FullCount = (AddrWidth + 1)'(numEntry);

	logic [AddrWidth-1:0] writePtr;
	logic [AddrWidth-1:0] retirePtr;

	assign writeAddr = writePtr;
	assign retireAddr = retirePtr;
	assign full = (count == FullCount);
	assign empty = (count == '0);

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clock) begin
		if (reset) begin
			writePtr <= '0;
			retirePtr <= '0;
		end else begin
			if (writeEn) begin
				writePtr <= writePtr + 1'b1;
			end
			if (retireEn) begin
				retirePtr <= retirePtr + 1'b1;
			end
		end
	end

	// Occupancy
	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({writeEn, retireEn})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// The table must hold back writes when full and retires when empty
	writeWhileFull: assert property (
		@(posedge clock) disable iff (reset)
		!(writeEn && full)
	) else $error("ringBuffCtrl: write while full");

	retireWhileEmpty: assert property (
		@(posedge clock) disable iff (reset)
		!(retireEn && empty)
	) else $error("ringBuffCtrl: retire while empty");

endmodule

// File: tbMpuIssueChecks.svh
`ifndef TBMPUISSUECHECKS_SVH
`define TBMPUISSUECHECKS_SVH

// Wrong values seen on DUT outputs
int valueErrors = 0;
// Ordering and timing rules broken
int ruleErrors = 0;

// Issued thread and its table slot
task automatic checkIssue(input issueInfoT expected, input issueInfoT actual);
	if (actual !== expected) begin
		valueErrors++;
		$display("ERROR at %0t: issue expected thread %0d no %0d, got thread %0d no %0d",
			$time, expected.threadId, expected.issueNo, actual.threadId, actual.issueNo);
	end
endtask

// Single-bit levels and strobes
task automatic checkFlag(
	input string name,
	input logic expected,
	input logic actual
);
	if (actual !== expected) begin
		valueErrors++;
		$display("ERROR at %0t: %s expected %b, got %b", $time, name, expected, actual);
	end
endtask

task automatic reportFailure(input string what);
	ruleErrors++;
	$display("FAILURE at %0t: %s", $time, what);
endtask

`endif

// File: tbMpuIssueStage.sv
`timescale 1ns/100ps

module tbMpuIssueStage;

	import mpuPkg::*;

	localparam int NumEntry = 8;
	localparam int NumRows = 20;
	localparam int MaxCycle = 4096;
	localparam int Never = 1000000;

	// Request plus cycles from its issue to its done
	typedef struct packed {
		threadReqT req;
		logic [7:0] doneDelay;
	} stimRowT;

	logic clock = 1'b0;
	logic reset;
	logic reqValid;
	threadReqT req;
	logic doneValid;
	threadIdT doneId;
	logic full;
	logic issueValid;
	issueInfoT issue;

	`include "tbMpuIssueChecks.svh"

	stimRowT stimTable [NumRows];
	// Reference model, edge numbers per request index
	int writeEdge [NumRows];
	int doneEdge [NumRows];
	int retireEdge [NumRows];
	bit doneBusy [MaxCycle];
	threadIdT doneThread [MaxCycle];
	int cyc = 0;
	int seed;
	int sent;
	int issued;
	int doneSent;
	bit sawFull;

	mpuIssueStage #(
		.numEntry(NumEntry)
	) mpuIssueStage_i (
		.clock(clock),
		.reset(reset),
		.reqValid(reqValid),
		.req(req),
		.doneValid(doneValid),
		.doneId(doneId),
		.full(full),
		.issueValid(issueValid),
		.issue(issue)
	);

	initial begin
		forever #4 clock = ~clock;
	end

	always @(posedge clock) cyc <= cyc + 1;

	task automatic loadRow(input int idx, input int tid, input bit hasSrc, input int src,
			input int delay);
		stimTable[idx].req.threadId = threadIdT'(tid);
		stimTable[idx].req.hasSrc = hasSrc;
		stimTable[idx].req.srcId = threadIdT'(src);
		stimTable[idx].doneDelay = 8'(delay);
	endtask

	task automatic loadTable();
		// Eight long-lived threads fill the table
		loadRow(0, 0, 0, 0, 12);
		// Done lands on the same edge as thread 0
		loadRow(1, 1, 0, 0, 11);
		loadRow(2, 2, 0, 0, 14);
		loadRow(3, 3, 0, 0, 13);
		loadRow(4, 4, 0, 0, 14);
		loadRow(5, 5, 0, 0, 12);
		loadRow(6, 6, 0, 0, 14);
		loadRow(7, 7, 0, 0, 10);
		loadRow(8, 8, 0, 0, 6);
		loadRow(9, 9, 1, 8, 3);
		// Independent, stuck behind thread 9
		loadRow(10, 10, 0, 0, 2);
		loadRow(11, 11, 1, 9, 4);
		loadRow(12, 12, 1, 3, 1);
		loadRow(13, 13, 0, 0, 5);
		loadRow(14, 14, 1, 13, 2);
		loadRow(15, 15, 1, 14, 7);
		loadRow(16, 16, 0, 0, 1);
		loadRow(17, 17, 0, 0, 1);
		loadRow(18, 18, 1, 16, 3);
		loadRow(19, 19, 1, 10, 2);
	endtask

	// Rows held in the table after edge n
	function automatic int occupancy(input int n);
		int cnt;
		cnt = 0;
		for (int i = 0; i < NumRows; i++) begin
			if (writeEdge[i] <= n) cnt++;
			if (retireEdge[i] <= n) cnt--;
		end
		return cnt;
	endfunction

	function automatic int findSource(input int k);
		int found;
		found = -1;
		for (int j = 0; j < k; j++) begin
			if (stimTable[j].req.threadId == stimTable[k].req.srcId) found = j;
		end
		return found;
	endfunction

	task automatic scheduleDone(input int k, input int n);
		int edgeNo;
		// Delay counts from the end of the cycle that carries the issue strobe
		edgeNo = n + 1 + stimTable[k].doneDelay;
		// One done per cycle, a clash is pushed back
		while (doneBusy[edgeNo]) begin
			edgeNo = edgeNo + 1 + ({$random(seed)} % 3);
		end
		doneBusy[edgeNo] = 1'b1;
		doneThread[edgeNo] = stimTable[k].req.threadId;
		doneEdge[k] = edgeNo;
		// Commit one edge after done, retire one after that, in order
		retireEdge[k] = edgeNo + 2;
		if (k > 0 && retireEdge[k-1] + 1 > retireEdge[k]) begin
			retireEdge[k] = retireEdge[k-1] + 1;
		end
	endtask

	task automatic observeIssue(input int n);
		issueInfoT expected;
		int src;
		if (issued >= NumRows) begin
			reportFailure("issue seen after every request had issued");
		end else begin
			expected = '0;
			expected.threadId = stimTable[issued].req.threadId;
			expected.issueNo = MaxIssueNoWidth'(issued % NumEntry);
			checkIssue(expected, issue);
			if (n < writeEdge[issued] + 1) begin
				reportFailure($sformatf("request %0d issued before it was written", issued));
			end
			if (stimTable[issued].req.hasSrc) begin
				src = findSource(issued);
				if (src < 0 || n < doneEdge[src] + 2) begin
					reportFailure($sformatf("thread %0d issued before its source %0d committed",
						expected.threadId, stimTable[issued].req.srcId));
				end
			end
			scheduleDone(issued, n);
			issued++;
		end
	endtask

	// Sample at the falling edge, then drive the next edge's inputs
	task automatic runCycle();
		int n;
		n = cyc;
		checkFlag("full", occupancy(n) == NumEntry, full);
		if (full === 1'b1) sawFull = 1'b1;
		if (issueValid === 1'b1) begin
			observeIssue(n);
		end else begin
			checkFlag("issueValid", 1'b0, issueValid);
		end
		if (sent < NumRows && full === 1'b0) begin
			reqValid = 1'b1;
			req = stimTable[sent].req;
			writeEdge[sent] = n + 1;
			sent++;
		end else begin
			reqValid = 1'b0;
			req = '0;
		end
		if (doneBusy[n + 1]) begin
			doneValid = 1'b1;
			doneId = doneThread[n + 1];
			doneSent++;
		end else begin
			doneValid = 1'b0;
			doneId = '0;
		end
	endtask

	initial begin
		seed = 32054;
		reset = 1'b1;
		reqValid = 1'b0;
		req = '0;
		doneValid = 1'b0;
		doneId = '0;
		sent = 0;
		issued = 0;
		doneSent = 0;
		sawFull = 1'b0;
		for (int i = 0; i < NumRows; i++) begin
			writeEdge[i] = Never;
			doneEdge[i] = Never;
			retireEdge[i] = Never;
		end
		for (int c = 0; c < MaxCycle; c++) begin
			doneBusy[c] = 1'b0;
		end
		loadTable();
		repeat (10) begin
			@(negedge clock);
			checkFlag("full", 1'b0, full);
			checkFlag("issueValid", 1'b0, issueValid);
		end
		reset = 1'b0;
		// First cycle out of reset
		@(negedge clock);
		checkFlag("full", 1'b0, full);
		checkFlag("issueValid", 1'b0, issueValid);
		while (!(issued == NumRows && doneSent == NumRows && occupancy(cyc) == 0)) begin
			runCycle();
			@(negedge clock);
		end
		if (!sawFull) reportFailure("full never rose with eight threads outstanding");
		$display("Checks done: %0d value errors, %0d other errors", valueErrors, ruleErrors);
		if (valueErrors + ruleErrors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// Watchdog
	initial begin
		int maxDelay;
		int limit;
		maxDelay = 0;
		@(negedge reset);
		for (int i = 0; i < NumRows; i++) begin
			if (stimTable[i].doneDelay > maxDelay) maxDelay = stimTable[i].doneDelay;
		end
		limit = NumRows * (maxDelay + 20);
		repeat (limit) @(posedge clock);
		$display("Timeout: the run did not finish within %0d cycles after reset", limit);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
